//--- interboard_pkg.sv
package interboard_pkg;

	// buffer sizing, shared by the send and receive FIFOs
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW = $clog2(FIFO_DEPTH); // 4 bits, used count is one wider

	// flow control
	// words kept free in the receive FIFO for flits already on the wire
	localparam int LINK_SLACK = 4;
	localparam int RX_READ_LIMIT = FIFO_DEPTH - LINK_SLACK; // read only below this fill

	// blocked-sender watchdog
	localparam int STALL_LIMIT = 32; // consecutive blocked cycles
	localparam int STALL_CW = $clog2(STALL_LIMIT + 1); // 6 bits, holds 0..STALL_LIMIT

	localparam int PAYLOAD_W = 10;

	// one link word, 11 bits
	typedef struct packed {
		logic last; // final flit of a packet
		logic [PAYLOAD_W-1:0] payload;
	} flit_t;

	// forward bundle on the link, 12 bits
	typedef struct packed {
		logic valid; // one flit per high cycle
		flit_t flit;
	} link_t;

	// sender states
	typedef enum logic [1:0] {
		LINK_DOWN, // waiting for the first read from the far end
		ACTIVE,
		STALLED // data pending but the far end holds read low
	} tx_state_t;

endpackage

//--- flit_fifo.sv
`timescale 1ns/10ps

module flit_fifo #(
	parameter int DEPTH = interboard_pkg::FIFO_DEPTH
) (
	input logic clk,
	input logic reset,
	input logic wrreq,
	input interboard_pkg::flit_t data,
	input logic rdreq,
	output interboard_pkg::flit_t q,
	output logic empty,
	output logic full,
	output logic [interboard_pkg::FIFO_AW:0] used
);
	import interboard_pkg::*;

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1; // pointer width

	flit_t mem [DEPTH]; // storage, no reset needed
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [FIFO_AW:0] count; // occupancy
	logic do_wr;
	logic do_rd;

	// requests that cannot be served are dropped here
	assign do_wr = wrreq && !full;
	assign do_rd = rdreq && !empty;

	// flags come straight off the count register,
	// so a write shows up one cycle after its edge
	assign empty = (count == '0);
	assign full = (count == (FIFO_AW+1)'(DEPTH));
	assign used = count;

	// pointers and count
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // wrap
			if (do_rd)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither, level stays
			endcase
		end
	end

	// data path
	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= data;
		if (do_rd)
			q <= mem[rd_ptr]; // head word appears the cycle after rdreq
	end

	// the writer must watch full and the reader must watch empty
	a_no_write_full: assert property (@(posedge clk) disable iff (reset)
		!(wrreq && full))
		else $error("flit_fifo write while full, flit dropped");

	a_no_read_empty: assert property (@(posedge clk) disable iff (reset)
		!(rdreq && empty))
		else $error("flit_fifo read while empty");

endmodule

//--- interboard_output.sv
`timescale 1ns/10ps

module interboard_output (
	input logic clk,
	input logic reset,
	input interboard_pkg::flit_t fifo_data, // q of the send FIFO
	input logic rdempty, // send FIFO empty
	input logic read_input, // read returned by the far end
	output logic rdreq, // pop the send FIFO
	output interboard_pkg::link_t link, // valid + flit toward the far end
	output interboard_pkg::tx_state_t state
);
	import interboard_pkg::*;

	tx_state_t state_d;
	logic valid_q; // lines up with q, one cycle after rdreq

	// next state
	always_comb begin
		state_d = state;
		unique case (state)
			LINK_DOWN: begin
				if (read_input)
					state_d = ACTIVE; // far end is up
			end
			ACTIVE: begin
				if (!read_input && !rdempty)
					state_d = STALLED; // blocked with data waiting
			end
			STALLED: begin
				if (read_input)
					state_d = ACTIVE;
			end
			default: state_d = LINK_DOWN;
		endcase
	end

	// pop whenever the far end allows it and there is something to send
	// STALLED may pop too, it is left on the next edge anyway
	assign rdreq = (state != LINK_DOWN) && read_input && !rdempty;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= LINK_DOWN;
			valid_q <= 1'b0;
		end else begin
			state <= state_d;
			valid_q <= rdreq; // flit arrives from the FIFO on the same cycle
		end
	end

	// q only holds a fresh word while valid is high, the far end ignores the rest
	assign link = '{valid: valid_q, flit: fifo_data};

	// the send FIFO head may only move together with a valid cycle
	a_flit_only_with_valid: assert property (@(posedge clk) disable iff (reset)
		!link.valid |-> $stable(fifo_data))
		else $error("interboard_output link flit changed without valid");

endmodule

//--- interboard_input.sv
`timescale 1ns/10ps

module interboard_input (
	input logic clk,
	input logic reset,
	input interboard_pkg::link_t link, // forward bundle from the sender
	input logic [interboard_pkg::FIFO_AW:0] wrusedw, // receive FIFO fill
	output interboard_pkg::flit_t data, // to the receive FIFO
	output logic wrreq,
	output logic read // flow control back to the sender
);
	import interboard_pkg::*;

	logic valid_q; // registered link valid
	flit_t flit_q; // registered link flit
	logic read_d;

	// leave LINK_SLACK words free, enough for what is already in flight
	// when read falls (pop, link stage, input stage)
	assign read_d = (wrusedw < (FIFO_AW+1)'(RX_READ_LIMIT));

	// control resets to an idle link that is ready to accept
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= 1'b0;
			read <= 1'b1;
		end else begin
			valid_q <= link.valid;
			read <= read_d; // lags the fill by one cycle
		end
	end

	// payload stage
	always_ff @(posedge clk) begin
		flit_q <= link.flit;
	end

	// every registered valid is one write
	assign wrreq = valid_q;
	assign data = flit_q;

	// sender honouring read plus the slack must keep the FIFO from overflowing
	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		wrreq |-> (wrusedw < (FIFO_AW+1)'(FIFO_DEPTH)))
		else $error("interboard_input write into a full receive FIFO");

endmodule

//--- link_stall_timer.sv
`timescale 1ns/10ps

module link_stall_timer (
	input logic clk,
	input logic reset,
	input interboard_pkg::tx_state_t state, // sender state, STALLED means blocked
	output logic link_stall
);
	import interboard_pkg::*;

	logic [STALL_CW-1:0] stall_cnt; // consecutive cycles in STALLED
	logic at_limit;

	assign at_limit = (stall_cnt == STALL_CW'(STALL_LIMIT));

	always_ff @(posedge clk) begin
		if (reset) begin
			stall_cnt <= '0;
		end else if (state != STALLED) begin
			stall_cnt <= '0; // sender moving again, start over
		end else if (!at_limit) begin
			stall_cnt <= stall_cnt + 1'b1; // saturates at the limit
		end
	end

	// flag drops as soon as the state leaves STALLED,
	// the count is cleared on the following edge
	assign link_stall = (state == STALLED) && at_limit;

	// a raised flag means the sender sat in STALLED for the whole window
	a_stall_window: assert property (@(posedge clk) disable iff (reset)
		$rose(link_stall) |-> $past(state == STALLED, STALL_LIMIT))
		else $error("link_stall raised without a full stall window");

endmodule

//--- interboard_link.sv
`timescale 1ns/10ps

module interboard_link (
	input logic clk,
	input logic reset,
	input interboard_pkg::flit_t in_flit, // local writer
	input logic in_wrreq,
	output logic in_full,
	input logic out_rdreq, // local reader
	output interboard_pkg::flit_t out_flit,
	output logic out_empty,
	output logic link_stall
);
	import interboard_pkg::*;

	// send side
	flit_t tx_q; // send FIFO head
	logic tx_empty;
	logic tx_rdreq;
	tx_state_t tx_state;

	// link between the boards, forward and return
	link_t link_fwd;
	logic link_read;

	// receive side
	flit_t rx_data;
	logic rx_wrreq;
	logic [FIFO_AW:0] rx_used;

	// send buffer, filled by the local writer
	flit_fifo #(
		.DEPTH(FIFO_DEPTH)
	) u_tx_fifo (
		.clk(clk),
		.reset(reset),
		.wrreq(in_wrreq),
		.data(in_flit),
		.rdreq(tx_rdreq),
		.q(tx_q),
		.empty(tx_empty),
		.full(in_full),
		.used() // fill not needed on this side
	);

	// drives the link from the send buffer
	interboard_output u_output (
		.clk(clk),
		.reset(reset),
		.fifo_data(tx_q),
		.rdempty(tx_empty),
		.read_input(link_read),
		.rdreq(tx_rdreq),
		.link(link_fwd),
		.state(tx_state)
	);

	// neighbour's input, looped straight back on this board
	interboard_input u_input (
		.clk(clk),
		.reset(reset),
		.link(link_fwd),
		.wrusedw(rx_used),
		.data(rx_data),
		.wrreq(rx_wrreq),
		.read(link_read)
	);

	// receive buffer, drained by the local reader
	flit_fifo #(
		.DEPTH(FIFO_DEPTH)
	) u_rx_fifo (
		.clk(clk),
		.reset(reset),
		.wrreq(rx_wrreq),
		.data(rx_data),
		.rdreq(out_rdreq),
		.q(out_flit),
		.empty(out_empty),
		.full(), // read flow control keeps it short of full
		.used(rx_used)
	);

	// watches the sender for a blocked link
	link_stall_timer u_stall_timer (
		.clk(clk),
		.reset(reset),
		.state(tx_state),
		.link_stall(link_stall)
	);

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int PERIOD = 40, // ns
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// synchronous reset, released on a rising edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

//--- interboard_link_tb.sv
`timescale 1ns/10ps

module interboard_link_tb;
	import interboard_pkg::*;

	localparam int BURST_LEN = 40;
	localparam int STALL_WAIT = STALL_LIMIT + 8; // flag must be up by then
	localparam int RECOVER_WAIT = 24; // a few reader pops plus read and state lag
	localparam int DRAIN_WAIT = 600;

	logic clk;
	logic reset;
	flit_t in_flit;
	logic in_wrreq;
	logic in_full;
	logic out_rdreq;
	flit_t out_flit;
	logic out_empty;
	logic link_stall;

	flit_t scoreboard [$]; // accepted flits, oldest first
	int value_errors;
	int timeout_errors;
	int accepted; // flits written into the DUT so far
	logic wr_last; // write driven on the previous edge
	logic rd_last; // pop driven on the previous edge, data due now
	logic full_seen; // in_full sampled at the last falling edge
	logic empty_seen; // out_empty sampled at the last falling edge

	tb_clock_gen #(
		.PERIOD(40),
		.RESET_CYCLES(16)
	) u_clock_gen (
		.clk(clk),
		.reset(reset)
	);

	interboard_link u_dut (
		.clk(clk),
		.reset(reset),
		.in_flit(in_flit),
		.in_wrreq(in_wrreq),
		.in_full(in_full),
		.out_rdreq(out_rdreq),
		.out_flit(out_flit),
		.out_empty(out_empty),
		.link_stall(link_stall)
	);

	function automatic flit_t random_flit();
		logic [31:0] r;
		flit_t f;
		r = $urandom();
		f.last = r[PAYLOAD_W];
		f.payload = r[PAYLOAD_W-1:0];
		return f;
	endfunction

	function automatic logic coin();
		logic [31:0] r;
		r = $urandom();
		return r[0];
	endfunction

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERR %s expected %h got %h", name, expected, actual);
			value_errors++;
		end
	endtask

	// one clock that drives on the rising edge and samples on the falling edge
	// writes and pops never go out on two edges in a row, so the flags seen
	// a cycle ago still hold when the request lands
	task automatic step(input logic try_write, input flit_t wdata, input logic try_read);
		logic check_now;
		flit_t expected;
		@(posedge clk);
		check_now = rd_last; // pop from the last edge shows up after this one
		if (try_write && !wr_last && !full_seen) begin
			in_flit <= wdata;
			in_wrreq <= 1'b1;
			scoreboard.push_back(wdata);
			accepted++;
			wr_last = 1'b1;
		end else begin
			in_wrreq <= 1'b0;
			wr_last = 1'b0;
		end
		if (try_read && !rd_last && !empty_seen) begin
			out_rdreq <= 1'b1;
			rd_last = 1'b1;
		end else begin
			out_rdreq <= 1'b0;
			rd_last = 1'b0;
		end
		@(negedge clk);
		if (check_now) begin
			if (scoreboard.size() == 0) begin
				$display("a flit was popped while none was expected");
				value_errors++;
			end else begin
				expected = scoreboard.pop_front();
				if (out_flit !== expected) begin
					$display("ERR out_flit expected %h got %h", expected, out_flit);
					value_errors++;
				end
			end
		end
		full_seen = in_full;
		empty_seen = out_empty;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) step(1'b0, '0, 1'b0);
	endtask

	// pop until the scoreboard runs dry
	task automatic drain(input int limit);
		int n;
		n = 0;
		while (scoreboard.size() != 0 && n < limit) begin
			step(1'b0, '0, 1'b1);
			n++;
		end
		if (scoreboard.size() != 0) begin
			$display("timeout while draining, %0d flits never arrived", scoreboard.size());
			timeout_errors++;
			scoreboard.delete();
		end
		idle(2);
		check_bit("out_empty", 1'b1, empty_seen);
	endtask

	// write with the reader stopped until the send FIFO reports full
	task automatic fill_link(output int total);
		int n;
		int start;
		n = 0;
		start = accepted;
		while (!full_seen && n < 400) begin
			step(1'b1, random_flit(), 1'b0);
			n++;
		end
		if (!full_seen) begin
			$display("timeout waiting for in_full with the reader stopped");
			timeout_errors++;
		end
		total = accepted - start;
	endtask

	task automatic reset_state();
		int n;
		repeat (4) @(negedge clk); // still inside reset
		check_bit("out_empty", 1'b1, out_empty);
		check_bit("in_full", 1'b0, in_full);
		check_bit("link_stall", 1'b0, link_stall);
		n = 0;
		while (reset && n < 64) begin
			@(negedge clk);
			n++;
		end
		if (reset) begin
			$display("timeout waiting for reset to be released");
			timeout_errors++;
		end
		idle(2);
		check_bit("out_empty", 1'b1, out_empty);
		check_bit("in_full", 1'b0, in_full);
		check_bit("link_stall", 1'b0, link_stall);
	endtask

	task automatic single_flit();
		flit_t f;
		int cycles;
		f.last = 1'b1;
		f.payload = 10'h2a5;
		step(1'b1, f, 1'b0);
		cycles = 0;
		while (empty_seen && cycles < 16) begin
			step(1'b0, '0, 1'b0);
			cycles++;
		end
		if (empty_seen) begin
			$display("timeout waiting for the single flit to reach the receive FIFO");
			timeout_errors++;
		end else if (cycles != 4) begin
			$display("out_empty fell %0d cycles after the write instead of 4", cycles);
			value_errors++;
		end
		drain(16); // checks last and payload against the scoreboard
	endtask

	task automatic random_burst();
		int n;
		int start;
		n = 0;
		start = accepted;
		while ((accepted - start < BURST_LEN || scoreboard.size() != 0) && n < 1000) begin
			step(accepted - start < BURST_LEN, random_flit(), coin()); // random reader
			n++;
		end
		if (accepted - start < BURST_LEN || scoreboard.size() != 0) begin
			$display("timeout in the random burst, %0d written, %0d outstanding",
				accepted - start, scoreboard.size());
			timeout_errors++;
			scoreboard.delete();
		end
		drain(16);
	endtask

	task automatic back_pressure();
		int total;
		fill_link(total);
		// send FIFO full plus the receive FIFO up to its limit and the in-flight flits
		if (total > 2 * FIFO_DEPTH || total < FIFO_DEPTH + RX_READ_LIMIT) begin
			$display("back-pressure accepted %0d flits, outside %0d to %0d",
				total, FIFO_DEPTH + RX_READ_LIMIT, 2 * FIFO_DEPTH);
			value_errors++;
		end
		drain(DRAIN_WAIT);
		check_bit("in_full", 1'b0, full_seen);
	endtask

	task automatic stall_flag();
		int total;
		int n;
		fill_link(total);
		n = 0;
		while (!link_stall && n < STALL_WAIT) begin
			step(1'b0, '0, 1'b0);
			n++;
		end
		if (!link_stall) begin
			$display("timeout waiting for link_stall with the receive side full");
			timeout_errors++;
		end
		n = 0;
		while (link_stall && n < RECOVER_WAIT) begin
			step(1'b0, '0, 1'b1); // reader back on so read returns
			n++;
		end
		if (link_stall) begin
			$display("timeout waiting for link_stall to clear after reading resumed");
			timeout_errors++;
		end
		drain(DRAIN_WAIT);
		check_bit("link_stall", 1'b0, link_stall);
	endtask

	initial begin
		void'($urandom(32'hd2b9_c323));
		in_flit = '0;
		in_wrreq = 1'b0;
		out_rdreq = 1'b0;
		value_errors = 0;
		timeout_errors = 0;
		accepted = 0;
		wr_last = 1'b0;
		rd_last = 1'b0;
		full_seen = 1'b0;
		empty_seen = 1'b1;

		reset_state();
		single_flit();
		random_burst();
		back_pressure();
		stall_flag();

		$display("errors: %0d value, %0d timeout, %0d flits sent",
			value_errors, timeout_errors, accepted);
		if (value_errors + timeout_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- interboard_link.f
interboard_pkg.sv
flit_fifo.sv
interboard_output.sv
interboard_input.sv
link_stall_timer.sv
interboard_link.sv
tb_clock_gen.sv
interboard_link_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the interboard link testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert \
	-f interboard_link.f \
	--top-module interboard_link_tb \
	-Mdir obj_dir -o sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
	echo "run_sim: verilator build failed with status $status, see $BUILD_LOG"
	exit 1
fi

./obj_dir/sim > "$SIM_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
	echo "run_sim: simulation exited with status $status, see $SIM_LOG"
	exit 1
fi

if grep -q "^Testbench passed$" "$SIM_LOG"; then
	echo "run_sim: simulation OK"
	exit 0
fi

echo "run_sim: simulation FAILED, see $SIM_LOG"
exit 1
